// File: src/coherence_pkg.sv
/*
 * Shared types for the snooping MESI bus and its L2 model.
 * Addresses are byte addresses carried in one 32-bit word; the L2
 * model only keeps L2_WORDS words and wraps higher addresses.
 */
package coherence_pkg;

    // one bus word, used for addresses and single L2 beats
    typedef logic [31:0] word_t;

    // bus controller FSM
    typedef enum logic [3:0] {
        IDLE,
        GRANT_R,
        GRANT_RX,
        GRANT_EVICT,
        GRANT_INV,
        SNOOP_R,
        SNOOP_RX,
        SNOOP_INV,
        TRANSFER_R,
        TRANSFER_RX,
        READ_L2,
        WRITEBACK_MS,        // cache to cache transfer plus writeback of dirty data
        WRITEBACK,
        BUS_TO_CACHE,
        INVALIDATE
    } bus_state_t;

    // L2 status; L2_ACCESS lasts exactly one cycle per access
    typedef enum logic [1:0] {
        L2_FREE,
        L2_BUSY,
        L2_ACCESS
    } l2_state_t;

    localparam int L2_WORDS = 256;    // words held by the L2 model

endpackage

// File: src/bus_ctrl.sv
`timescale 1ns/1ps

/*
 * MESI snooping bus controller, one transaction at a time.
 * Fixed priority: evict, read-exclusive, read, invalidate; highest cache
 * index wins within a kind. Needs CPUS >= 2 and BLOCK_SIZE a power of two.
 * abort_bus drops the transaction on the next edge without waiting for L2,
 * so an access already issued to L2 still completes there.
 */
module bus_ctrl #(
    parameter int BLOCK_SIZE = 2,
    parameter int CPUS       = 4
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic [CPUS-1:0]                      dREN,
    input  logic [CPUS-1:0]                      dWEN,
    input  logic [CPUS-1:0]                      ccwrite,
    input  coherence_pkg::word_t [CPUS-1:0]      daddr,
    input  logic [CPUS-1:0][BLOCK_SIZE*32-1:0]   dstore,
    input  logic [CPUS-1:0]                      ccsnoophit,
    input  logic [CPUS-1:0]                      ccIsPresent,
    input  logic [CPUS-1:0]                      ccdirty,
    input  logic [CPUS-1:0]                      ccsnoopdone,
    input  coherence_pkg::word_t                 l2load,
    input  coherence_pkg::l2_state_t             l2state,
    input  logic                                 abort_bus,
    output logic [CPUS-1:0]                      dwait,
    output logic [CPUS-1:0]                      ccwait,
    output logic [CPUS-1:0]                      ccinv,
    output logic [CPUS-1:0]                      ccexclusive,
    output logic [CPUS-1:0][BLOCK_SIZE*32-1:0]   dload,
    output coherence_pkg::word_t [CPUS-1:0]      ccsnoopaddr,
    output coherence_pkg::word_t                 l2addr,
    output coherence_pkg::word_t                 l2store,
    output logic                                 l2REN,
    output logic                                 l2WEN
);
    import coherence_pkg::*;

    localparam int    OFFSET_W   = $clog2(BLOCK_SIZE) + 2;   // byte + word offset in a block
    localparam int    CPU_W      = $clog2(CPUS);
    localparam int    BEAT_W     = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;
    localparam word_t BLOCK_MASK = ~word_t'((1 << OFFSET_W) - 1);

    bus_state_t state, nstate;

    logic [CPU_W-1:0]  requester, nrequester;
    logic [CPU_W-1:0]  supplier, nsupplier;
    logic              rx_txn, nrx_txn;          // read-exclusive in flight
    logic              exclusive_q, nexclusive;  // no other cache holds the block
    logic [BEAT_W-1:0] beat, nbeat, beat_nx;
    logic              last_beat;
    logic              l2_done;
    logic              wb_first;                 // first cycle of WRITEBACK_MS

    // snoop answers collected while the snoopers report at their own pace
    logic [CPUS-1:0] snoop_done_q, snoop_hit_q, snoop_pres_q, snoop_dirty_q;
    logic [CPUS-1:0] nsnoop_done, nsnoop_hit, nsnoop_pres, nsnoop_dirty;
    logic            in_snoop, snoop_all;

    logic [CPUS-1:0] others;
    logic [CPUS-1:0] rx_req, rd_req, inv_req;

    word_t [CPUS-1:0]        nccsnoopaddr;
    word_t                   nl2addr, nl2store, req_block_addr;
    logic [BLOCK_SIZE*32-1:0] ndload, wb_block;

    // highest set index wins
    function automatic logic [CPU_W-1:0] prio_enc(input logic [CPUS-1:0] v);
        logic [CPU_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (v[i])
                idx = CPU_W'(i);
        end
        return idx;
    endfunction

    assign rx_req  = dREN & ccwrite;
    assign rd_req  = dREN & ~ccwrite;
    assign inv_req = ccwrite & ~dREN;

    assign others         = ~(CPUS'(1) << requester);
    assign req_block_addr = daddr[requester] & BLOCK_MASK;

    assign in_snoop     = (state == SNOOP_R) || (state == SNOOP_RX) || (state == SNOOP_INV);
    assign nsnoop_done  = snoop_done_q | (ccsnoopdone & others);
    assign nsnoop_hit   = snoop_hit_q | (ccsnoophit & ccsnoopdone & others);
    assign nsnoop_pres  = snoop_pres_q | (ccIsPresent & ccsnoopdone & others);
    assign nsnoop_dirty = snoop_dirty_q | (ccdirty & ccsnoopdone & others);
    assign snoop_all    = &(nsnoop_done | ~others);   // every non-requester has reported

    assign l2_done   = (l2state == L2_ACCESS);
    assign last_beat = (beat == BEAT_W'(BLOCK_SIZE - 1));
    assign beat_nx   = beat + 1'b1;
    assign wb_block  = (state == WRITEBACK_MS) ? dload[requester] : dstore[requester];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state         <= IDLE;
            requester     <= '0;
            supplier      <= '0;
            rx_txn        <= 1'b0;
            exclusive_q   <= 1'b0;
            beat          <= '0;
            wb_first      <= 1'b0;
            snoop_done_q  <= '0;
            snoop_hit_q   <= '0;
            snoop_pres_q  <= '0;
            snoop_dirty_q <= '0;
            ccsnoopaddr   <= '0;
            dload         <= '0;
            l2addr        <= '0;
            l2store       <= '0;
        end else begin
            state                <= nstate;
            requester            <= nrequester;
            supplier             <= nsupplier;
            rx_txn               <= nrx_txn;
            exclusive_q          <= nexclusive;
            beat                 <= nbeat;
            wb_first             <= (nstate == WRITEBACK_MS) && (state != WRITEBACK_MS);
            ccsnoopaddr          <= nccsnoopaddr;
            dload[requester]     <= ndload;     // only the requester's block changes
            l2addr               <= nl2addr;
            l2store              <= nl2store;
            if (state == IDLE) begin
                snoop_done_q  <= '0;
                snoop_hit_q   <= '0;
                snoop_pres_q  <= '0;
                snoop_dirty_q <= '0;
            end else if (in_snoop) begin
                snoop_done_q  <= nsnoop_done;
                snoop_hit_q   <= nsnoop_hit;
                snoop_pres_q  <= nsnoop_pres;
                snoop_dirty_q <= nsnoop_dirty;
            end
        end
    end

    // next state
    always_comb begin
        nstate = state;
        case (state)
            IDLE: begin
                if (|dWEN)
                    nstate = GRANT_EVICT;
                else if (|rx_req)
                    nstate = GRANT_RX;
                else if (|rd_req)
                    nstate = GRANT_R;
                else if (|inv_req)
                    nstate = GRANT_INV;
            end
            GRANT_R:     nstate = SNOOP_R;
            GRANT_RX:    nstate = SNOOP_RX;
            GRANT_INV:   nstate = SNOOP_INV;
            GRANT_EVICT: nstate = WRITEBACK;
            SNOOP_R: begin
                if (snoop_all)
                    nstate = (|nsnoop_hit) ? TRANSFER_R : READ_L2;
            end
            SNOOP_RX: begin
                if (snoop_all)
                    nstate = (|nsnoop_hit) ? TRANSFER_RX : READ_L2;
            end
            SNOOP_INV: begin
                if (snoop_all)
                    nstate = INVALIDATE;
            end
            TRANSFER_R:  nstate = snoop_dirty_q[supplier] ? WRITEBACK_MS : BUS_TO_CACHE;
            TRANSFER_RX: nstate = BUS_TO_CACHE;   // new owner takes the dirty data as M
            READ_L2: begin
                if (l2_done && last_beat)
                    nstate = BUS_TO_CACHE;
            end
            WRITEBACK_MS, WRITEBACK: begin
                if (l2_done && last_beat)
                    nstate = IDLE;
            end
            BUS_TO_CACHE, INVALIDATE: nstate = IDLE;
            default:                  nstate = IDLE;
        endcase
        if (abort_bus)
            nstate = IDLE;
    end

    // outputs and datapath
    always_comb begin
        nrequester   = requester;
        nsupplier    = supplier;
        nrx_txn      = rx_txn;
        nexclusive   = exclusive_q;
        nbeat        = beat;
        nccsnoopaddr = ccsnoopaddr;
        nl2addr      = l2addr;
        nl2store     = l2store;
        ndload       = dload[requester];
        dwait        = '1;
        ccwait       = '0;
        ccinv        = '0;
        ccexclusive  = '0;
        l2REN        = 1'b0;
        l2WEN        = 1'b0;
        case (state)
            IDLE: begin
                nbeat   = '0;
                nrx_txn = ~(|dWEN) & (|rx_req);
                if (|dWEN)
                    nrequester = prio_enc(dWEN);
                else if (|rx_req)
                    nrequester = prio_enc(rx_req);
                else if (|rd_req)
                    nrequester = prio_enc(rd_req);
                else if (|inv_req)
                    nrequester = prio_enc(inv_req);
            end
            GRANT_R, GRANT_RX, GRANT_INV: begin
                for (int i = 0; i < CPUS; i++) begin
                    if (others[i])
                        nccsnoopaddr[i] = req_block_addr;
                end
            end
            GRANT_EVICT: begin
                nl2addr  = req_block_addr;
                nl2store = dstore[requester][31:0];   // first beat ready for the L2 request
            end
            SNOOP_R, SNOOP_RX: begin
                ccwait = others;
                if (state == SNOOP_RX)
                    ccinv = others;
                nl2addr    = req_block_addr;
                nsupplier  = prio_enc(nsnoop_hit);
                nexclusive = ~(|nsnoop_pres);
            end
            SNOOP_INV: begin
                ccwait = others;
                ccinv  = others;
            end
            TRANSFER_R, TRANSFER_RX: begin
                ccwait = others;
                if (state == TRANSFER_RX)
                    ccinv = others;    // late snoopers may still be catching up
                ndload   = dstore[supplier];
                nl2store = dstore[supplier][31:0];
            end
            READ_L2: begin
                l2REN = ~l2_done;   // drop for the strobe cycle so L2 sees a fresh request
                if (l2_done) begin
                    ndload[beat*32 +: 32] = l2load;
                    nbeat = last_beat ? '0 : beat_nx;
                    if (!last_beat)
                        nl2addr = l2addr + 32'd4;
                end
            end
            WRITEBACK_MS, WRITEBACK: begin
                l2WEN = ~l2_done;
                if ((state == WRITEBACK_MS) && wb_first) begin
                    dwait[requester]       = 1'b0;   // requester already has its data
                    ccexclusive[requester] = exclusive_q;
                end
                if (l2_done) begin
                    nbeat = last_beat ? '0 : beat_nx;
                    if (!last_beat) begin
                        nl2addr  = l2addr + 32'd4;
                        nl2store = wb_block[beat_nx*32 +: 32];
                    end else if (state == WRITEBACK) begin
                        dwait[requester] = 1'b0;     // eviction done
                    end
                end
            end
            BUS_TO_CACHE: begin
                dwait[requester]       = 1'b0;
                ccexclusive[requester] = exclusive_q;
                if (rx_txn)
                    ccinv = others;
            end
            INVALIDATE: dwait[requester] = 1'b0;
            default: ;
        endcase
    end

endmodule

// File: src/l2_mem.sv
`timescale 1ns/1ps

/*
 * L2 model with a fixed access latency, word addressed modulo L2_WORDS.
 * A request is only taken in L2_FREE; L2_LATENCY must be at least 2.
 * Reset fills every word with 16'hC0DE over its own word index.
 */
module l2_mem #(
    parameter int L2_LATENCY = 3
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  coherence_pkg::word_t     l2addr,
    input  coherence_pkg::word_t     l2store,
    input  logic                     l2REN,
    input  logic                     l2WEN,
    output coherence_pkg::word_t     l2load,
    output coherence_pkg::l2_state_t l2state
);
    import coherence_pkg::*;

    localparam int IDX_W = $clog2(L2_WORDS);
    localparam int CNT_W = $clog2(L2_LATENCY + 1);

    word_t            mem [L2_WORDS];
    logic [IDX_W-1:0] idx_q;      // word index latched with the request
    word_t            data_q;
    logic             wen_q;
    logic [CNT_W-1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < L2_WORDS; i++) begin
                mem[i] <= {16'hC0DE, 16'(i)};
            end
            l2state <= L2_FREE;
            l2load  <= '0;
            count   <= '0;
            idx_q   <= '0;
            data_q  <= '0;
            wen_q   <= 1'b0;
        end else begin
            case (l2state)
                L2_FREE: begin
                    if (l2REN || l2WEN) begin
                        l2state <= L2_BUSY;
                        count   <= CNT_W'(L2_LATENCY - 1);
                        idx_q   <= l2addr[2 +: IDX_W];   // drop the byte offset
                        data_q  <= l2store;
                        wen_q   <= l2WEN;                // write wins if both are up
                    end
                end
                L2_BUSY: begin
                    if (count <= CNT_W'(1)) begin
                        l2state <= L2_ACCESS;
                        l2load  <= mem[idx_q];           // read data valid in the strobe cycle
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                L2_ACCESS: begin
                    if (wen_q)
                        mem[idx_q] <= data_q;
                    l2state <= L2_FREE;
                end
                default: l2state <= L2_FREE;
            endcase
        end
    end

endmodule

// File: src/coherence_bus_top.sv
`timescale 1ns/1ps

/*
 * Bus controller joined to the L2 model. The L1 caches sit outside and
 * talk over the per-cache ports; the L2 side stays internal.
 */
module coherence_bus_top #(
    parameter int BLOCK_SIZE = 2,
    parameter int CPUS       = 4,
    parameter int L2_LATENCY = 3
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 abort_bus,
    input  logic [CPUS-1:0]                      dREN,
    input  logic [CPUS-1:0]                      dWEN,
    input  logic [CPUS-1:0]                      ccwrite,
    input  coherence_pkg::word_t [CPUS-1:0]      daddr,
    input  logic [CPUS-1:0][BLOCK_SIZE*32-1:0]   dstore,
    input  logic [CPUS-1:0]                      ccsnoophit,
    input  logic [CPUS-1:0]                      ccIsPresent,
    input  logic [CPUS-1:0]                      ccdirty,
    input  logic [CPUS-1:0]                      ccsnoopdone,
    output logic [CPUS-1:0]                      dwait,
    output logic [CPUS-1:0]                      ccwait,
    output logic [CPUS-1:0]                      ccinv,
    output logic [CPUS-1:0]                      ccexclusive,
    output logic [CPUS-1:0][BLOCK_SIZE*32-1:0]   dload,
    output coherence_pkg::word_t [CPUS-1:0]      ccsnoopaddr
);
    import coherence_pkg::*;

    word_t     l2addr, l2store, l2load;
    logic      l2REN, l2WEN;
    l2_state_t l2state;

    bus_ctrl #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .CPUS       (CPUS)
    ) i_bus_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .ccwrite     (ccwrite),
        .daddr       (daddr),
        .dstore      (dstore),
        .ccsnoophit  (ccsnoophit),
        .ccIsPresent (ccIsPresent),
        .ccdirty     (ccdirty),
        .ccsnoopdone (ccsnoopdone),
        .l2load      (l2load),
        .l2state     (l2state),
        .abort_bus   (abort_bus),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccexclusive (ccexclusive),
        .dload       (dload),
        .ccsnoopaddr (ccsnoopaddr),
        .l2addr      (l2addr),
        .l2store     (l2store),
        .l2REN       (l2REN),
        .l2WEN       (l2WEN)
    );

    l2_mem #(
        .L2_LATENCY (L2_LATENCY)
    ) i_l2_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .l2addr  (l2addr),
        .l2store (l2store),
        .l2REN   (l2REN),
        .l2WEN   (l2WEN),
        .l2load  (l2load),
        .l2state (l2state)
    );

endmodule

// File: tests/tb_coherence_bus.sv
`timescale 1ns/1ps

/*
 * Testbench for the coherence bus top level with default parameters
 * (4 caches, 2-word blocks). Plays the L1 side of the bus. Requests come
 * from a table and snoop answers come after a random delay with the hit
 * and dirty bits of the current row. Stops at the first mismatch.
 */
module tb_coherence_bus;
    import coherence_pkg::*;

    localparam int    CPUS       = 4;
    localparam int    BLOCK_SIZE = 2;
    localparam int    NROWS      = 8;
    localparam int    TIMEOUT    = 100;                        // cycles per wait
    localparam word_t BLOCK_MASK = ~word_t'(BLOCK_SIZE*4 - 1);  // clears byte and word offset
    localparam int    K_READ = 0, K_RX = 1, K_EVICT = 2, K_INV = 3;

    logic                               CLK = 1'b0;
    logic                               nRST, abort_bus;
    logic [CPUS-1:0]                    dREN, dWEN, ccwrite;
    word_t [CPUS-1:0]                   daddr;
    logic [CPUS-1:0][BLOCK_SIZE*32-1:0] dstore;
    logic [CPUS-1:0]                    ccsnoophit, ccIsPresent, ccdirty, ccsnoopdone;
    logic [CPUS-1:0]                    dwait, ccwait, ccinv, ccexclusive;
    logic [CPUS-1:0][BLOCK_SIZE*32-1:0] dload;
    word_t [CPUS-1:0]                   ccsnoopaddr;

    // stimulus and expected values with one transaction per row
    int                       t_req   [NROWS];
    int                       t_kind  [NROWS];
    word_t                    t_addr  [NROWS];
    logic [BLOCK_SIZE*32-1:0] t_block [NROWS];
    logic [CPUS-1:0]          t_hits  [NROWS];
    logic                     t_dirty [NROWS];
    logic [BLOCK_SIZE*32-1:0] t_dload [NROWS];
    logic                     t_excl  [NROWS];

    logic [CPUS-1:0] cur_hits;      // snoop answers for the row in flight
    logic            cur_dirty;
    logic [CPUS-1:0] snoop_req;
    int              snoop_delay [CPUS];
    int              seed = 32'h330e;

    coherence_bus_top i_coherence_bus_top (
        .CLK         (CLK),
        .nRST        (nRST),
        .abort_bus   (abort_bus),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .ccwrite     (ccwrite),
        .daddr       (daddr),
        .dstore      (dstore),
        .ccsnoophit  (ccsnoophit),
        .ccIsPresent (ccIsPresent),
        .ccdirty     (ccdirty),
        .ccsnoopdone (ccsnoopdone),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccexclusive (ccexclusive),
        .dload       (dload),
        .ccsnoopaddr (ccsnoopaddr)
    );

    always #2 CLK = ~CLK;

    task automatic end_with_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
            end_with_failure($sformatf("ERROR %0t: %s is %h, expected %h",
                                       $time, what, got, exp));
    endtask

    // L2 block right after reset holds C0DE over each word index
    function automatic logic [BLOCK_SIZE*32-1:0] reset_block(input word_t addr);
        logic [BLOCK_SIZE*32-1:0] blk;
        word_t                    word_idx;
        for (int b = 0; b < BLOCK_SIZE; b++) begin
            word_idx = ((addr & BLOCK_MASK) >> 2) + word_t'(b);
            blk[b*32 +: 32] = {16'hC0DE, 16'(word_idx % L2_WORDS)};
        end
        return blk;
    endfunction

    task automatic put_row(input int r, input int req, input int kind, input word_t addr,
                           input logic [63:0] blk, input logic [CPUS-1:0] hits,
                           input logic dirty, input logic [63:0] exp_dload, input logic excl);
        t_req[r]   = req;
        t_kind[r]  = kind;
        t_addr[r]  = addr;
        t_block[r] = blk;
        t_hits[r]  = hits;
        t_dirty[r] = dirty;
        t_dload[r] = exp_dload;
        t_excl[r]  = excl;
    endtask

    // call right after a rising edge
    task automatic raise_request(input int c, input int kind, input word_t addr);
        daddr[c] <= addr;
        case (kind)
            K_READ:  dREN[c] <= 1'b1;
            K_RX: begin
                dREN[c]    <= 1'b1;
                ccwrite[c] <= 1'b1;
            end
            K_EVICT: dWEN[c] <= 1'b1;
            default: ccwrite[c] <= 1'b1;
        endcase
    endtask

    task automatic drop_request(input int c);
        @(posedge CLK);
        dREN[c]    <= 1'b0;
        dWEN[c]    <= 1'b0;
        ccwrite[c] <= 1'b0;
    endtask

    // waits for dwait low on any cache in mask; also collects ccinv pulses meanwhile
    task automatic wait_release(input logic [CPUS-1:0] mask, output int who,
                                output logic [CPUS-1:0] inv_seen);
        int cycles;
        cycles   = 0;
        who      = -1;
        inv_seen = '0;
        while (who < 0) begin
            @(negedge CLK);
            inv_seen |= ccinv;
            for (int i = 0; i < CPUS; i++) begin
                if (mask[i] && !dwait[i])
                    who = i;
            end
            cycles++;
            if (who < 0 && cycles > TIMEOUT)
                end_with_failure($sformatf("timed out waiting for dwait to drop on caches %b",
                                           mask));
        end
    endtask

    // L1 snoop responder where each snooped cache answers after its own delay
    initial begin
        ccsnoophit  <= '0;
        ccIsPresent <= '0;
        ccdirty     <= '0;
        ccsnoopdone <= '0;
        forever begin
            @(negedge CLK);
            snoop_req = ccwait;
            @(posedge CLK);
            for (int i = 0; i < CPUS; i++) begin
                if (!snoop_req[i]) begin
                    ccsnoopdone[i] <= 1'b0;
                    ccsnoophit[i]  <= 1'b0;
                    ccIsPresent[i] <= 1'b0;
                    ccdirty[i]     <= 1'b0;
                    snoop_delay[i] = $random(seed) & 3;
                end else if (snoop_delay[i] > 0) begin
                    snoop_delay[i] = snoop_delay[i] - 1;
                end else begin
                    ccsnoopdone[i] <= 1'b1;
                    ccsnoophit[i]  <= cur_hits[i];
                    ccIsPresent[i] <= cur_hits[i];
                    ccdirty[i]     <= cur_hits[i] & cur_dirty;
                end
            end
        end
    end

    initial begin
        int              who;
        int              holder;
        logic [CPUS-1:0] inv_seen;
        logic [CPUS-1:0] onehot;
        logic [CPUS-1:0] inv_exp;
        nRST      <= 1'b0;
        abort_bus <= 1'b0;
        dREN      <= '0;
        dWEN      <= '0;
        ccwrite   <= '0;
        daddr     <= '0;
        dstore    <= '0;
        cur_hits  <= '0;
        cur_dirty <= 1'b0;

        put_row(0, 1, K_READ,  32'h44,  64'h0, 4'b0000, 1'b0, reset_block(32'h44), 1'b1);
        put_row(1, 2, K_EVICT, 32'h80,  64'h1111_2222_3333_4444, 4'b0000, 1'b0, 64'h0, 1'b0);
        put_row(2, 0, K_READ,  32'h84,  64'h0, 4'b0000, 1'b0, 64'h1111_2222_3333_4444, 1'b1);
        put_row(3, 3, K_READ,  32'hC0,  64'h5A5A_0C0C_A5A5_C0C0, 4'b0110, 1'b0,
                64'h5A5A_0C0C_A5A5_C0C0, 1'b0);                  // clean supplier
        put_row(4, 0, K_READ,  32'h100, 64'hDEAD_0104_BEEF_0100, 4'b1010, 1'b1,
                64'hDEAD_0104_BEEF_0100, 1'b0);                  // dirty supplier
        put_row(5, 2, K_READ,  32'h104, 64'h0, 4'b0000, 1'b0, 64'hDEAD_0104_BEEF_0100, 1'b1);
        put_row(6, 1, K_INV,   32'h140, 64'h0, 4'b0000, 1'b0, 64'h0, 1'b0);
        put_row(7, 3, K_RX,    32'h188, 64'h7777_0188_6666_0180, 4'b0001, 1'b0,
                64'h7777_0188_6666_0180, 1'b0);

        @(posedge CLK);
        @(negedge CLK);
        check_value(64'(dwait), 64'hF, "dwait in reset");
        check_value(64'(ccwait), 64'h0, "ccwait in reset");
        check_value(64'(ccinv), 64'h0, "ccinv in reset");
        check_value(64'(ccexclusive), 64'h0, "ccexclusive in reset");
        check_value(64'(dload[0]), 64'h0, "dload in reset");
        @(posedge CLK);
        nRST <= 1'b1;

        for (int r = 0; r < NROWS; r++) begin
            @(posedge CLK);
            cur_hits  <= t_hits[r];
            cur_dirty <= t_dirty[r];
            holder = t_req[r];          // highest hitting cache supplies the block
            for (int i = 0; i < CPUS; i++) begin
                if (t_hits[r][i])
                    holder = i;
            end
            for (int i = 0; i < CPUS; i++) begin
                dstore[i] <= (i == holder) ? t_block[r] : ~t_block[r];
            end
            raise_request(t_req[r], t_kind[r], t_addr[r]);
            onehot  = CPUS'(1) << t_req[r];
            inv_exp = (t_kind[r] == K_RX || t_kind[r] == K_INV) ? ~onehot : '0;
            wait_release(onehot, who, inv_seen);
            if (t_kind[r] == K_READ || t_kind[r] == K_RX)
                check_value(64'(dload[t_req[r]]), t_dload[r], $sformatf("row %0d dload", r));
            check_value(64'(ccexclusive), 64'(t_excl[r] ? onehot : '0),
                        $sformatf("row %0d ccexclusive", r));
            check_value(64'(inv_seen), 64'(inv_exp), $sformatf("row %0d ccinv", r));
            if (t_kind[r] != K_EVICT) begin
                for (int i = 0; i < CPUS; i++) begin
                    if (i != t_req[r])
                        check_value(64'(ccsnoopaddr[i]), 64'(t_addr[r] & BLOCK_MASK),
                                    $sformatf("row %0d ccsnoopaddr[%0d]", r, i));
                end
            end
            drop_request(t_req[r]);
        end

        // eviction beats a read raised in the same cycle
        @(posedge CLK);
        cur_hits  <= '0;
        cur_dirty <= 1'b0;
        dstore[0] <= 64'h0BAD_0204_0BAD_0200;
        raise_request(3, K_READ, 32'h1C0);
        raise_request(0, K_EVICT, 32'h200);
        wait_release(4'b1001, who, inv_seen);
        check_value(64'(who), 64'd0, "first served of evict and read");
        drop_request(0);
        wait_release(4'b1000, who, inv_seen);
        check_value(64'(dload[3]), reset_block(32'h1C0), "dload after evict");
        drop_request(3);

        // of two reads raised at once the higher index goes first
        @(posedge CLK);
        raise_request(1, K_READ, 32'h240);
        raise_request(2, K_READ, 32'h280);
        wait_release(4'b0110, who, inv_seen);
        check_value(64'(who), 64'd2, "first served of two reads");
        check_value(64'(dload[2]), reset_block(32'h280), "dload of cache 2");
        drop_request(2);
        wait_release(4'b0010, who, inv_seen);
        check_value(64'(dload[1]), reset_block(32'h240), "dload of cache 1");
        drop_request(1);

        repeat (2) @(posedge CLK);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: coherence_bus_top.f
src/coherence_pkg.sv
src/bus_ctrl.sv
src/l2_mem.sv
src/coherence_bus_top.sv
tests/tb_coherence_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the coherence bus testbench with Verilator and runs it.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --top-module tb_coherence_bus \
        -f coherence_bus_top.f -o sim_tb; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
    exit 0
fi

echo "pass message not found"
exit 1
